//--- logic/rfid_cmd_pkg.sv
// rfid command parser package
// command and phase encodings plus field widths of the supported tag commands
package rfid_cmd_pkg;

  // command codes found by the upstream decoder
  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_QUERY,
    CMD_QUERYADJ,
    CMD_ACK,
    CMD_REQRN,
    CMD_READ,
    CMD_WRITE
  } cmd_e;

  // parser phases, one per field of a packet
  typedef enum logic [3:0] {
    PH_IDLE,
    PH_SEL,
    PH_SKIP,
    PH_Q,
    PH_UPDN,
    PH_BANK,
    PH_PTR,
    PH_WORDS,
    PH_DATA,
    PH_HANDLE,
    PH_DONE
  } phase_e;

  // handle, rn and write data share one width
  localparam int HANDLE_W = 16;
  localparam int PTR_W    = 7;
  localparam int WORDS_W  = 8;
  localparam int BANK_W   = 2;
  localparam int Q_W      = 4;
  localparam int UPDN_W   = 3;
  localparam int SEL_W    = 2;

  // ebv-8: one continue flag then seven value bits
  localparam int EBV_BYTE_W = 8;

  // bits ignored between fields
  localparam int QUERY_SKIP_LEN    = 7;
  localparam int QUERYADJ_SKIP_LEN = 2;

  localparam int FIFO_DEPTH = 4;

  // packed record, cmd in the msbs and write data in the lsbs
  localparam int CMD_REC_W = $bits(cmd_e) + 1 + SEL_W + Q_W + UPDN_W + BANK_W +
                             PTR_W + WORDS_W + HANDLE_W;

endpackage

//--- logic/handle_checker.sv
// handle checker
// compares 16 serial bits, msb first, against the tag handle
`timescale 1ns/100ps

module handle_checker (
  input  logic                              bitinclk,
  input  logic                              reset,
  input  logic                              start,
  input  logic                              bit_en,
  input  logic                              bitin,
  input  logic [rfid_cmd_pkg::HANDLE_W-1:0] handle,
  output logic                              done,
  output logic                              ok
);
  import rfid_cmd_pkg::*;

  // position of the next bit, 0 is the handle msb
  logic [$clog2(HANDLE_W)-1:0] idx;
  // sticky, set by the first differing bit
  logic                        mismatch;

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      idx      <= '0;
      mismatch <= 1'b0;
      done     <= 1'b0;
    end else if (start) begin
      idx      <= '0;
      mismatch <= 1'b0;
      done     <= 1'b0;
    end else if (bit_en && !done) begin
      idx <= idx + 1'b1;
      if (bitin != handle[HANDLE_W - 1 - int'(idx)]) begin
        mismatch <= 1'b1;
      end
      // 16th bit closes the compare
      if (int'(idx) == HANDLE_W - 1) begin
        done <= 1'b1;
      end
    end
  end

  // valid from the cycle after the last bit until the next start
  assign ok = done && !mismatch;

endmodule

//--- logic/ebv_pointer.sv
// ebv-8 word pointer decoder
// skips bytes whose continue flag is set, keeps 7 value bits of the last byte
`timescale 1ns/100ps

module ebv_pointer (
  input  logic                           bitinclk,
  input  logic                           reset,
  input  logic                           start,
  input  logic                           bit_en,
  input  logic                           bitin,
  output logic                           done,
  output logic [rfid_cmd_pkg::PTR_W-1:0] ptr
);
  import rfid_cmd_pkg::*;

  // bit position inside the current byte, 0 holds the continue flag
  logic [$clog2(EBV_BYTE_W)-1:0] pos;
  // current byte had flag 0
  logic                          last;
  logic                          take;

  assign take = bit_en && !done;

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      pos  <= '0;
      last <= 1'b0;
      done <= 1'b0;
    end else if (start) begin
      pos  <= '0;
      last <= 1'b0;
      done <= 1'b0;
    end else if (take) begin
      // byte counter wraps into the next byte
      pos <= pos + 1'b1;
      if (pos == '0) begin
        last <= !bitin;
      end
      if (last && int'(pos) == EBV_BYTE_W - 1) begin
        done <= 1'b1;
      end
    end
  end

  // value bits of the final byte, shifted in msb first
  always_ff @(posedge bitinclk) begin
    if (start) begin
      ptr <= '0;
    end else if (take && last && pos != '0) begin
      ptr <= {ptr[PTR_W-2:0], bitin};
    end
  end

  // pointer is final once done, until the next packet
  assert property (@(posedge bitinclk) disable iff (reset)
    done && !start |=> $stable(ptr));

endmodule

//--- logic/field_parser.sv
// command field parser
// steps through the fields of one packet and holds the finished record
`timescale 1ns/100ps

module field_parser (
  input  logic                              bitinclk,
  input  logic                              reset,
  input  logic                              packet_start,
  input  rfid_cmd_pkg::cmd_e                packet_cmd,
  input  logic                              bitin,
  input  logic                              bit_valid,
  input  logic [rfid_cmd_pkg::HANDLE_W-1:0] currenthandle,
  input  logic [rfid_cmd_pkg::HANDLE_W-1:0] currentrn,
  input  logic                              rec_ready,
  output logic                              bit_ready,
  output logic                              rec_valid,
  output rfid_cmd_pkg::cmd_e                rec_cmd,
  output logic                              rec_handle_ok,
  output logic [rfid_cmd_pkg::SEL_W-1:0]    rec_sel,
  output logic [rfid_cmd_pkg::Q_W-1:0]      rec_q,
  output logic [rfid_cmd_pkg::UPDN_W-1:0]   rec_updn,
  output logic [rfid_cmd_pkg::BANK_W-1:0]   rec_bank,
  output logic [rfid_cmd_pkg::PTR_W-1:0]    rec_ptr,
  output logic [rfid_cmd_pkg::WORDS_W-1:0]  rec_words,
  output logic [rfid_cmd_pkg::HANDLE_W-1:0] rec_data
);
  import rfid_cmd_pkg::*;

  phase_e                      phase;
  cmd_e                        cmd;
  // bit index inside a fixed-length field
  logic [$clog2(HANDLE_W)-1:0] cnt;
  logic                        take;
  logic                        start;
  logic                        field_last;
  logic                        has_handle;
  logic                        ptr_done;
  logic                        hc_done;
  logic                        hc_ok;

  // first field of each command
  function automatic phase_e first_phase(cmd_e c);
    case (c)
      CMD_QUERY:           return PH_SEL;
      CMD_QUERYADJ:        return PH_SKIP;
      CMD_ACK, CMD_REQRN:  return PH_HANDLE;
      CMD_READ, CMD_WRITE: return PH_BANK;
      default:             return PH_IDLE;
    endcase
  endfunction

  // field order per command
  function automatic phase_e next_phase(phase_e ph, cmd_e c);
    case (ph)
      PH_SEL:            return PH_SKIP;
      PH_SKIP:           return (c == CMD_QUERY) ? PH_Q : PH_UPDN;
      PH_BANK:           return PH_PTR;
      PH_PTR:            return (c == CMD_READ) ? PH_WORDS : PH_DATA;
      PH_WORDS, PH_DATA: return PH_HANDLE;
      default:           return PH_DONE;
    endcase
  endfunction

  // length of fixed fields where data and handle both use HANDLE_W
  function automatic int field_len(phase_e ph, cmd_e c);
    case (ph)
      PH_SEL:   return SEL_W;
      PH_SKIP:  return (c == CMD_QUERY) ? QUERY_SKIP_LEN : QUERYADJ_SKIP_LEN;
      PH_Q:     return Q_W;
      PH_UPDN:  return UPDN_W;
      PH_BANK:  return BANK_W;
      PH_WORDS: return WORDS_W;
      default:  return HANDLE_W;
    endcase
  endfunction

  // high in idle to take packet_start and low while a record waits
  // and for the one cycle the pointer decoder needs to finish
  assign bit_ready  = (phase != PH_DONE) && !(phase == PH_PTR && ptr_done);
  // bits taken in idle carry no field and are ignored
  assign take       = bit_valid && bit_ready;
  assign start      = packet_start && phase == PH_IDLE;
  assign field_last = int'(cnt) == field_len(phase, cmd) - 1;
  assign has_handle = cmd inside {CMD_ACK, CMD_REQRN, CMD_READ, CMD_WRITE};

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      phase <= PH_IDLE;
      cmd   <= CMD_NONE;
      cnt   <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (packet_start) begin
            cmd   <= packet_cmd;
            phase <= first_phase(packet_cmd);
          end
        end
        // ebv length is open so wait for the decoder
        PH_PTR: begin
          if (ptr_done) begin
            phase <= next_phase(phase, cmd);
          end
        end
        PH_DONE: begin
          if (rec_ready) begin
            phase <= PH_IDLE;
          end
        end
        default: begin
          if (take) begin
            if (field_last) begin
              cnt   <= '0;
              phase <= next_phase(phase, cmd);
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // field capture is cleared per packet so absent fields read 0
  always_ff @(posedge bitinclk) begin
    if (start) begin
      rec_sel   <= '0;
      rec_q     <= '0;
      rec_updn  <= '0;
      rec_bank  <= '0;
      rec_words <= '0;
      rec_data  <= '0;
    end else if (take) begin
      case (phase)
        PH_SEL:   rec_sel   <= {rec_sel[SEL_W-2:0], bitin};
        PH_Q:     rec_q     <= {rec_q[Q_W-2:0], bitin};
        PH_UPDN:  rec_updn  <= {rec_updn[UPDN_W-2:0], bitin};
        PH_BANK:  rec_bank  <= {rec_bank[BANK_W-2:0], bitin};
        PH_WORDS: rec_words <= {rec_words[WORDS_W-2:0], bitin};
        // write data arrives scrambled with the current rn
        PH_DATA:  rec_data  <= {rec_data[HANDLE_W-2:0],
                                bitin ^ currentrn[HANDLE_W - 1 - int'(cnt)]};
        default: ;
      endcase
    end
  end

  ebv_pointer i_ebv (
    .bitinclk (bitinclk),
    .reset    (reset),
    .start    (start),
    .bit_en   (take && phase == PH_PTR),
    .bitin    (bitin),
    .done     (ptr_done),
    .ptr      (rec_ptr)
  );

  handle_checker i_handle (
    .bitinclk (bitinclk),
    .reset    (reset),
    .start    (start),
    .bit_en   (take && phase == PH_HANDLE),
    .bitin    (bitin),
    .handle   (currenthandle),
    .done     (hc_done),
    .ok       (hc_ok)
  );

  assign rec_valid     = phase == PH_DONE;
  assign rec_cmd       = cmd;
  assign rec_handle_ok = has_handle ? hc_ok : 1'b1;

  // incoming bits leave a waiting record untouched until the fifo takes it
  assert property (@(posedge bitinclk) disable iff (reset)
    rec_valid && !rec_ready |=> rec_valid && $stable({rec_cmd, rec_handle_ok,
      rec_sel, rec_q, rec_updn, rec_bank, rec_ptr, rec_words, rec_data}));

  assert property (@(posedge bitinclk) disable iff (reset)
    packet_start |-> phase == PH_IDLE);

  // the checker must have seen all 16 bits before the record goes out
  assert property (@(posedge bitinclk) disable iff (reset)
    rec_valid && has_handle |-> hc_done);

endmodule

//--- logic/cmd_fifo.sv
// command record fifo
// circular buffer of parsed records, oldest on the read side
`timescale 1ns/100ps

module cmd_fifo (
  input  logic                               bitinclk,
  input  logic                               reset,
  input  logic                               wr_valid,
  input  logic [rfid_cmd_pkg::CMD_REC_W-1:0] wr_data,
  input  logic                               rd_ready,
  output logic                               wr_ready,
  output logic                               rd_valid,
  output logic [rfid_cmd_pkg::CMD_REC_W-1:0] rd_data
);
  import rfid_cmd_pkg::*;

  logic [CMD_REC_W-1:0]            mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rptr;
  // occupancy, needs one value more than the pointers
  logic [$clog2(FIFO_DEPTH+1)-1:0] count;
  logic                            push;
  logic                            pop;

  assign wr_ready = int'(count) != FIFO_DEPTH;
  assign rd_valid = count != '0;
  assign rd_data  = mem[rptr];
  assign push     = wr_valid && wr_ready;
  assign pop      = rd_valid && rd_ready;

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= (int'(wptr) == FIFO_DEPTH - 1) ? '0 : wptr + 1'b1;
      end
      if (pop) begin
        rptr <= (int'(rptr) == FIFO_DEPTH - 1) ? '0 : rptr + 1'b1;
      end
      // simultaneous push and pop keep the count
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge bitinclk) begin
    if (push) begin
      mem[wptr] <= wr_data;
    end
  end

  assert property (@(posedge bitinclk) disable iff (reset)
    int'(count) <= FIFO_DEPTH);

endmodule

//--- logic/cmd_dispatch.sv
// command dispatch
// drops records that failed the handle check and registers the rest for the controller
`timescale 1ns/100ps

module cmd_dispatch (
  input  logic                               bitinclk,
  input  logic                               reset,
  input  logic                               rd_valid,
  input  logic [rfid_cmd_pkg::CMD_REC_W-1:0] rd_data,
  input  logic                               cmd_ready,
  output logic                               rd_ready,
  output logic                               cmd_valid,
  output rfid_cmd_pkg::cmd_e                 cmd_cmd,
  output logic [rfid_cmd_pkg::SEL_W-1:0]     cmd_sel,
  output logic [rfid_cmd_pkg::Q_W-1:0]       cmd_q,
  output logic [rfid_cmd_pkg::UPDN_W-1:0]    cmd_updn,
  output logic [rfid_cmd_pkg::BANK_W-1:0]    cmd_bank,
  output logic [rfid_cmd_pkg::PTR_W-1:0]     cmd_ptr,
  output logic [rfid_cmd_pkg::WORDS_W-1:0]   cmd_words,
  output logic [rfid_cmd_pkg::HANDLE_W-1:0]  cmd_data,
  output logic [7:0]                         drop_count
);
  import rfid_cmd_pkg::*;

  logic [$bits(cmd_e)-1:0] f_cmd;
  logic                    f_ok;
  logic [SEL_W-1:0]        f_sel;
  logic [Q_W-1:0]          f_q;
  logic [UPDN_W-1:0]       f_updn;
  logic [BANK_W-1:0]       f_bank;
  logic [PTR_W-1:0]        f_ptr;
  logic [WORDS_W-1:0]      f_words;
  logic [HANDLE_W-1:0]     f_data;
  logic                    pop;

  // record layout, cmd in the msbs
  assign {f_cmd, f_ok, f_sel, f_q, f_updn, f_bank, f_ptr, f_words, f_data} = rd_data;

  // output register free now or emptied this cycle
  assign rd_ready = !cmd_valid || cmd_ready;
  assign pop      = rd_valid && rd_ready;

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      cmd_valid  <= 1'b0;
      drop_count <= '0;
    end else if (pop) begin
      cmd_valid <= f_ok;
      // failed handle, counted and never shown
      if (!f_ok && drop_count != 8'hff) begin
        drop_count <= drop_count + 8'd1;
      end
    end else if (cmd_ready) begin
      cmd_valid <= 1'b0;
    end
  end

  always_ff @(posedge bitinclk) begin
    if (pop && f_ok) begin
      cmd_cmd   <= cmd_e'(f_cmd);
      cmd_sel   <= f_sel;
      cmd_q     <= f_q;
      cmd_updn  <= f_updn;
      cmd_bank  <= f_bank;
      cmd_ptr   <= f_ptr;
      cmd_words <= f_words;
      cmd_data  <= f_data;
    end
  end

  // controller sees a steady command while it stalls
  assert property (@(posedge bitinclk) disable iff (reset)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable({cmd_cmd, cmd_sel, cmd_q,
      cmd_updn, cmd_bank, cmd_ptr, cmd_words, cmd_data}));

endmodule

//--- logic/packet_parse_top.sv
// packet parse top level
// parser feeds the record fifo, dispatch hands commands to the controller
`timescale 1ns/100ps

module packet_parse_top (
  input  logic                               bitinclk,
  input  logic                               reset,
  input  logic                               packet_start,
  input  rfid_cmd_pkg::cmd_e                 packet_cmd,
  input  logic                               bitin,
  input  logic                               bit_valid,
  output logic                               bit_ready,
  input  logic [rfid_cmd_pkg::HANDLE_W-1:0]  currenthandle,
  input  logic [rfid_cmd_pkg::HANDLE_W-1:0]  currentrn,
  input  logic                               cmd_ready,
  output logic                               cmd_valid,
  output rfid_cmd_pkg::cmd_e                 cmd_cmd,
  output logic [rfid_cmd_pkg::SEL_W-1:0]     cmd_sel,
  output logic [rfid_cmd_pkg::Q_W-1:0]       cmd_q,
  output logic [rfid_cmd_pkg::UPDN_W-1:0]    cmd_updn,
  output logic [rfid_cmd_pkg::BANK_W-1:0]    cmd_bank,
  output logic [rfid_cmd_pkg::PTR_W-1:0]     cmd_ptr,
  output logic [rfid_cmd_pkg::WORDS_W-1:0]   cmd_words,
  output logic [rfid_cmd_pkg::HANDLE_W-1:0]  cmd_data,
  output logic [7:0]                         drop_count
);
  import rfid_cmd_pkg::*;

  logic                 rec_valid;
  logic                 rec_ready;
  cmd_e                 rec_cmd;
  logic                 rec_handle_ok;
  logic [SEL_W-1:0]     rec_sel;
  logic [Q_W-1:0]       rec_q;
  logic [UPDN_W-1:0]    rec_updn;
  logic [BANK_W-1:0]    rec_bank;
  logic [PTR_W-1:0]     rec_ptr;
  logic [WORDS_W-1:0]   rec_words;
  logic [HANDLE_W-1:0]  rec_data;
  logic [CMD_REC_W-1:0] wr_data;
  logic                 rd_valid;
  logic                 rd_ready;
  logic [CMD_REC_W-1:0] rd_data;

  field_parser i_parser (
    .bitinclk      (bitinclk),
    .reset         (reset),
    .packet_start  (packet_start),
    .packet_cmd    (packet_cmd),
    .bitin         (bitin),
    .bit_valid     (bit_valid),
    .currenthandle (currenthandle),
    .currentrn     (currentrn),
    .rec_ready     (rec_ready),
    .bit_ready     (bit_ready),
    .rec_valid     (rec_valid),
    .rec_cmd       (rec_cmd),
    .rec_handle_ok (rec_handle_ok),
    .rec_sel       (rec_sel),
    .rec_q         (rec_q),
    .rec_updn      (rec_updn),
    .rec_bank      (rec_bank),
    .rec_ptr       (rec_ptr),
    .rec_words     (rec_words),
    .rec_data      (rec_data)
  );

  // same field order that dispatch unpacks
  assign wr_data = {rec_cmd, rec_handle_ok, rec_sel, rec_q, rec_updn, rec_bank,
                    rec_ptr, rec_words, rec_data};

  cmd_fifo i_fifo (
    .bitinclk (bitinclk),
    .reset    (reset),
    .wr_valid (rec_valid),
    .wr_data  (wr_data),
    .rd_ready (rd_ready),
    .wr_ready (rec_ready),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  cmd_dispatch i_dispatch (
    .bitinclk   (bitinclk),
    .reset      (reset),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .cmd_ready  (cmd_ready),
    .rd_ready   (rd_ready),
    .cmd_valid  (cmd_valid),
    .cmd_cmd    (cmd_cmd),
    .cmd_sel    (cmd_sel),
    .cmd_q      (cmd_q),
    .cmd_updn   (cmd_updn),
    .cmd_bank   (cmd_bank),
    .cmd_ptr    (cmd_ptr),
    .cmd_words  (cmd_words),
    .cmd_data   (cmd_data),
    .drop_count (drop_count)
  );

endmodule

//--- verification/tb_packet_tasks.svh
// directed tests for the packet parser testbench
// bit drivers, packet senders with expected records, and the checks

function automatic exp_rec_t make_rec(input cmd_e c, input logic [SEL_W-1:0] sel,
                                      input logic [Q_W-1:0] q,
                                      input logic [UPDN_W-1:0] updn,
                                      input logic [BANK_W-1:0] bank,
                                      input logic [PTR_W-1:0] ptr,
                                      input logic [WORDS_W-1:0] words,
                                      input logic [HANDLE_W-1:0] data);
  exp_rec_t r;
  r.cmd   = c;
  r.sel   = sel;
  r.q     = q;
  r.updn  = updn;
  r.bank  = bank;
  r.ptr   = ptr;
  r.words = words;
  r.data  = data;
  return r;
endfunction

task automatic report_fail(input string msg);
  errors++;
  $display("[FAIL] %0t: %s", $time, msg);
endtask

// called on a falling edge, returns on the falling edge after the bit was taken
task automatic send_bit(input logic b);
  bit_valid = 1'b1;
  bitin     = b;
  while (!bit_ready) @(negedge bitinclk);
  last_bit_cycle = cycle;
  @(negedge bitinclk);
  bit_valid = 1'b0;
endtask

// msb first
task automatic send_field(input logic [31:0] val, input int len);
  for (int i = len - 1; i >= 0; i--) begin
    send_bit(val[i]);
  end
endtask

task automatic start_packet(input cmd_e c);
  // a record still waiting for the fifo keeps bit_ready low
  while (!bit_ready) @(negedge bitinclk);
  packet_start = 1'b1;
  packet_cmd   = c;
  @(negedge bitinclk);
  packet_start = 1'b0;
  packet_cmd   = CMD_NONE;
endtask

// leading bytes carry the continue flag and junk value bits
task automatic send_ebv(input logic [PTR_W-1:0] ptr, input int nbytes);
  logic [31:0] r;
  for (int i = 1; i < nbytes; i++) begin
    r = $urandom;
    send_field({24'd0, 1'b1, r[6:0]}, EBV_BYTE_W);
  end
  send_field({24'd0, 1'b0, ptr}, EBV_BYTE_W);
endtask

task automatic send_query(output exp_rec_t exp);
  logic [31:0] r;
  r = $urandom;
  start_packet(CMD_QUERY);
  send_field(32'(r[1:0]), SEL_W);
  send_field(32'(r[8:2]), QUERY_SKIP_LEN);
  send_field(32'(r[12:9]), Q_W);
  exp = make_rec(CMD_QUERY, r[1:0], r[12:9], '0, '0, '0, '0, '0);
endtask

task automatic send_queryadj(output exp_rec_t exp);
  logic [31:0] r;
  r = $urandom;
  start_packet(CMD_QUERYADJ);
  send_field(32'(r[1:0]), QUERYADJ_SKIP_LEN);
  send_field(32'(r[4:2]), UPDN_W);
  exp = make_rec(CMD_QUERYADJ, '0, '0, r[4:2], '0, '0, '0, '0);
endtask

task automatic send_handle_cmd(input cmd_e c, input logic [HANDLE_W-1:0] h,
                               output exp_rec_t exp);
  start_packet(c);
  send_field(32'(h), HANDLE_W);
  exp = make_rec(c, '0, '0, '0, '0, '0, '0, '0);
endtask

task automatic send_read(input int nbytes, output exp_rec_t exp);
  logic [31:0] r;
  r = $urandom;
  start_packet(CMD_READ);
  send_field(32'(r[1:0]), BANK_W);
  send_ebv(r[8:2], nbytes);
  send_field(32'(r[16:9]), WORDS_W);
  send_field(32'(currenthandle), HANDLE_W);
  exp = make_rec(CMD_READ, '0, '0, '0, r[1:0], r[8:2], r[16:9], '0);
endtask

// data on the air is scrambled, the tag sees it xor the current rn
task automatic send_write(input int nbytes, output exp_rec_t exp);
  logic [31:0] r;
  logic [31:0] sent;
  r    = $urandom;
  sent = $urandom;
  start_packet(CMD_WRITE);
  send_field(32'(r[1:0]), BANK_W);
  send_ebv(r[8:2], nbytes);
  send_field(32'(sent[15:0]), HANDLE_W);
  send_field(32'(currenthandle), HANDLE_W);
  exp = make_rec(CMD_WRITE, '0, '0, '0, r[1:0], r[8:2], '0, sent[15:0] ^ currentrn);
endtask

// waits for cmd_valid and compares, cmd_ready must be high
task automatic check_cmd(input exp_rec_t exp, input bit check_lat);
  exp_rec_t got;
  int       waited;
  waited = 0;
  while (!cmd_valid && waited < CHECK_WAIT) begin
    @(negedge bitinclk);
    waited++;
  end
  if (!cmd_valid) begin
    errors++;
    $display("no command reached the controller at %0t, expected cmd %0d", $time, exp.cmd);
  end else begin
    got = {cmd_cmd, cmd_sel, cmd_q, cmd_updn, cmd_bank, cmd_ptr, cmd_words, cmd_data};
    if (check_lat && cycle - last_bit_cycle != CMD_LATENCY) begin
      report_fail($sformatf("cmd_valid %0d cycles after last bit, expected %0d",
                            cycle - last_bit_cycle, CMD_LATENCY));
    end
    if (got !== exp) begin
      report_fail($sformatf("cmd %0d record %h, expected %h", exp.cmd, got, exp));
    end
    // step past the transfer
    @(negedge bitinclk);
  end
endtask

// one handle bit flipped, record must vanish and be counted
task automatic check_dropped(input cmd_e c);
  exp_rec_t   exp;
  logic [31:0] r;
  logic [7:0]  drops;
  bit          seen;
  drops = drop_count;
  r     = $urandom;
  seen  = 1'b0;
  send_handle_cmd(c, currenthandle ^ (16'h0001 << r[3:0]), exp);
  repeat (2 * CMD_LATENCY) begin
    if (cmd_valid) seen = 1'b1;
    @(negedge bitinclk);
  end
  if (seen) begin
    errors++;
    $display("command %0d with a wrong handle reached the controller", c);
  end
  if (drop_count !== drops + 8'd1) begin
    report_fail($sformatf("drop_count %0d, expected %0d", drop_count, drops + 8'd1));
  end
endtask

task automatic test_query_queryadj();
  exp_rec_t exp;
  repeat (3) begin
    send_query(exp);
    check_cmd(exp, 1'b1);
  end
  repeat (3) begin
    send_queryadj(exp);
    check_cmd(exp, 1'b1);
  end
endtask

task automatic test_read();
  exp_rec_t exp;
  send_read(1, exp);
  check_cmd(exp, 1'b1);
  send_read(2, exp);
  check_cmd(exp, 1'b1);
endtask

task automatic test_write();
  exp_rec_t exp;
  send_write(1, exp);
  check_cmd(exp, 1'b1);
  send_write(2, exp);
  check_cmd(exp, 1'b1);
endtask

task automatic test_handle_check();
  exp_rec_t exp;
  send_handle_cmd(CMD_ACK, currenthandle, exp);
  check_cmd(exp, 1'b1);
  send_handle_cmd(CMD_REQRN, currenthandle, exp);
  check_cmd(exp, 1'b1);
  check_dropped(CMD_ACK);
  check_dropped(CMD_REQRN);
endtask

// controller stalls, fifo fills, parser holds the last record
task automatic test_backpressure();
  exp_rec_t exp;
  bit       stalled;
  cmd_ready = 1'b0;
  for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
    case (i % 6)
      0:       send_query(exp);
      1:       send_read(2, exp);
      2:       send_handle_cmd(CMD_ACK, currenthandle, exp);
      3:       send_write(1, exp);
      4:       send_queryadj(exp);
      default: send_handle_cmd(CMD_REQRN, currenthandle, exp);
    endcase
    pend.push_back(exp);
  end
  stalled = 1'b1;
  repeat (4) begin
    if (bit_ready) stalled = 1'b0;
    @(negedge bitinclk);
  end
  if (!stalled) begin
    errors++;
    $display("bit_ready stayed high with a full fifo and a stalled controller");
  end
  cmd_ready = 1'b1;
  // all records in send order
  while (pend.size() > 0) begin
    exp = pend.pop_front();
    check_cmd(exp, 1'b0);
  end
endtask

//--- verification/tb_packet_parse.sv
// testbench for the rfid packet parser
// directed packets through parser, fifo and dispatch, checked at the controller side
`timescale 1ns/100ps

module tb_packet_parse;
  import rfid_cmd_pkg::*;

  // run limit in clock cycles, well above the length of all tests
  localparam int MAX_CYCLES  = 3000;
  // last accepted bit to cmd_valid with an empty path
  localparam int CMD_LATENCY = 3;
  // longest wait for a command before it counts as missing
  localparam int CHECK_WAIT  = 16;

  // expected command as the controller should see it
  typedef struct packed {
    cmd_e                cmd;
    logic [SEL_W-1:0]    sel;
    logic [Q_W-1:0]      q;
    logic [UPDN_W-1:0]   updn;
    logic [BANK_W-1:0]   bank;
    logic [PTR_W-1:0]    ptr;
    logic [WORDS_W-1:0]  words;
    logic [HANDLE_W-1:0] data;
  } exp_rec_t;

  logic                bitinclk;
  logic                reset;
  logic                packet_start;
  cmd_e                packet_cmd;
  logic                bitin;
  logic                bit_valid;
  logic                bit_ready;
  logic [HANDLE_W-1:0] currenthandle;
  logic [HANDLE_W-1:0] currentrn;
  logic                cmd_ready;
  logic                cmd_valid;
  cmd_e                cmd_cmd;
  logic [SEL_W-1:0]    cmd_sel;
  logic [Q_W-1:0]      cmd_q;
  logic [UPDN_W-1:0]   cmd_updn;
  logic [BANK_W-1:0]   cmd_bank;
  logic [PTR_W-1:0]    cmd_ptr;
  logic [WORDS_W-1:0]  cmd_words;
  logic [HANDLE_W-1:0] cmd_data;
  logic [7:0]          drop_count;

  int                  errors = 0;
  int                  cycle = 0;
  // cycle count on the falling edge where the latest bit was taken
  int                  last_bit_cycle = 0;
  logic [31:0]         rnd;
  // records queued while the controller stalls
  exp_rec_t            pend[$];

  packet_parse_top i_dut (
    .bitinclk      (bitinclk),
    .reset         (reset),
    .packet_start  (packet_start),
    .packet_cmd    (packet_cmd),
    .bitin         (bitin),
    .bit_valid     (bit_valid),
    .bit_ready     (bit_ready),
    .currenthandle (currenthandle),
    .currentrn     (currentrn),
    .cmd_ready     (cmd_ready),
    .cmd_valid     (cmd_valid),
    .cmd_cmd       (cmd_cmd),
    .cmd_sel       (cmd_sel),
    .cmd_q         (cmd_q),
    .cmd_updn      (cmd_updn),
    .cmd_bank      (cmd_bank),
    .cmd_ptr       (cmd_ptr),
    .cmd_words     (cmd_words),
    .cmd_data      (cmd_data),
    .drop_count    (drop_count)
  );

  // 100 ns bit clock
  initial begin
    bitinclk = 1'b0;
    forever #50 bitinclk = ~bitinclk;
  end

  always @(posedge bitinclk) begin
    cycle <= cycle + 1;
  end

  `include "tb_packet_tasks.svh"

  // stops a hung run
  initial begin
    wait (cycle >= MAX_CYCLES);
    $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    // one seed for the whole run
    rnd           = $urandom(57568);
    reset         = 1'b1;
    packet_start  = 1'b0;
    packet_cmd    = CMD_NONE;
    bitin         = 1'b0;
    bit_valid     = 1'b0;
    cmd_ready     = 1'b1;
    rnd           = $urandom;
    currenthandle = rnd[15:0];
    rnd           = $urandom;
    currentrn     = rnd[15:0];
    repeat (3) @(negedge bitinclk);
    reset = 1'b0;
    @(negedge bitinclk);

    test_query_queryadj();
    test_read();
    test_write();
    test_handle_check();
    test_backpressure();

    $display("test run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+verification
logic/rfid_cmd_pkg.sv
logic/handle_checker.sv
logic/ebv_pointer.sv
logic/field_parser.sv
logic/cmd_fifo.sv
logic/cmd_dispatch.sv
logic/packet_parse_top.sv
verification/tb_packet_parse.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rfid packet parser testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_packet_parse -f files.f --Mdir obj_dir -o tb_packet_parse
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_packet_parse > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides pass or fail
if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
exit 0
